// ==== source/axi_bus_params.svh ====
`ifndef AXI_BUS_PARAMS_SVH
`define AXI_BUS_PARAMS_SVH

// Bus widths
`define AXI_ADDR_W   32
`define AXI_DATA_W   32
`define AXI_STRB_W   4

// Bus topology
`define MASTER_COUNT 2
`define SLAVE_COUNT  4

// Window number sits just above the 256 MiB window offset
`define WINDOW_SHIFT 28

// On-chip words per window
`define SLAVE_WORDS  64

// LED status pages
`define PAGE_COUNT   16

`endif

// ==== source/axi_bus_pkg.sv ====
`include "axi_bus_params.svh"

package axi_bus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Same codes as the AXI RESP field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } bus_resp_e;

    typedef logic [$clog2(`MASTER_COUNT)-1:0] master_idx_t;
    typedef logic [$clog2(`SLAVE_COUNT)-1:0]  window_idx_t;
    typedef logic [$clog2(`SLAVE_WORDS)-1:0]  word_idx_t;

    // Single-beat request from a master
    typedef struct packed {
        logic                   valid;
        bus_op_e                op;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [`AXI_STRB_W-1:0] wstrb;
    } bus_req_t;

    typedef struct packed {
        logic                   valid;
        bus_op_e                op;
        master_idx_t            master;
        window_idx_t            window;
        logic                   dec_err;
        word_idx_t              word;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [`AXI_STRB_W-1:0] wstrb;
    } bus_stage_t;

    typedef struct packed {
        logic                   valid;
        bus_resp_e              resp;
        logic [`AXI_DATA_W-1:0] rdata;
    } bus_rsp_t;

endpackage

// ==== source/status_pkg.sv ====
`include "axi_bus_params.svh"

package status_pkg;

    typedef logic [$clog2(`PAGE_COUNT)-1:0] page_idx_t;

    // Fixed test patterns shown on pages 8 to 15
    localparam logic [0:7][7:0] PAGE_PATTERNS = {
        8'h00,
        8'h0F,
        8'hF0,
        8'h0F,
        8'hAA,
        8'h55,
        8'hF0,
        8'h0F
    };

endpackage

// ==== source/bus_decode.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module bus_decode import axi_bus_pkg::*; (
    input  logic                     sys_clk,
    input  logic                     arst_n,
    input  bus_req_t                 req [`MASTER_COUNT],
    output logic [`MASTER_COUNT-1:0] req_ready,
    input  logic                     stage_free,
    output bus_stage_t               dec_stage
);

    master_idx_t last_grant;
    master_idx_t grant;
    logic        grant_valid;
    logic        dec_free;
    logic        load;
    logic        dec_valid;
    bus_req_t    sel_req;
    bus_stage_t  dec_q;

    // Round robin, search starts just after the last winner
    always_comb begin
        master_idx_t cand;
        grant_valid = 1'b0;
        grant       = last_grant;
        for (int i = 1; i <= `MASTER_COUNT; i++) begin
            cand = master_idx_t'((int'(last_grant) + i) % `MASTER_COUNT);
            if (!grant_valid && req[cand].valid) begin
                grant_valid = 1'b1;
                grant       = cand;
            end
        end
    end

    // Free when empty or when execute takes our entry
    assign dec_free = !dec_valid || stage_free;
    assign load     = grant_valid && dec_free;
    assign sel_req  = req[grant];

    always_comb begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            req_ready[m] = load && (grant == master_idx_t'(m));
        end
    end

    // Master 0 wins the first arbitration after reset
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            last_grant <= master_idx_t'(`MASTER_COUNT - 1);
            dec_valid  <= 1'b0;
        end else if (dec_free) begin
            dec_valid <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load) begin
            dec_q.valid   <= 1'b1;
            dec_q.op      <= sel_req.op;
            dec_q.master  <= grant;
            dec_q.window  <= sel_req.addr[`WINDOW_SHIFT +: $bits(window_idx_t)];
            // Anything above the window bits is unmapped
            dec_q.dec_err <= |sel_req.addr[`AXI_ADDR_W-1:`WINDOW_SHIFT+$bits(window_idx_t)];
            dec_q.word    <= sel_req.addr[$clog2(`AXI_STRB_W) +: $bits(word_idx_t)];
            dec_q.wdata   <= sel_req.wdata;
            dec_q.wstrb   <= sel_req.wstrb;
        end
    end

    always_comb begin
        dec_stage       = dec_q;
        dec_stage.valid = dec_valid;
    end

endmodule

// ==== source/bus_execute.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module bus_execute import axi_bus_pkg::*; (
    input  logic        sys_clk,
    input  logic        arst_n,
    input  bus_stage_t  dec_stage,
    output logic        stage_free,
    input  logic        out_free,
    output bus_rsp_t    exec_rsp,
    output master_idx_t exec_master,
    output logic [1:0]  exec_valid_bits
);

    // One small memory per address window
    logic [`AXI_DATA_W-1:0] mem [`SLAVE_COUNT][`SLAVE_WORDS];

    logic                   exec_valid;
    logic                   fire;
    bus_resp_e              resp_q;
    logic [`AXI_DATA_W-1:0] rdata_q;
    master_idx_t            master_q;

    // Free when empty or when the result stage takes our entry
    assign stage_free = !exec_valid || out_free;
    assign fire       = dec_stage.valid && stage_free;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_valid <= 1'b0;
        end else if (stage_free) begin
            exec_valid <= dec_stage.valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fire) begin
            master_q <= dec_stage.master;
            if (dec_stage.dec_err) begin
                resp_q  <= RESP_DECERR;
                rdata_q <= '0;
            end else if (dec_stage.op == OP_WRITE) begin
                resp_q  <= RESP_OKAY;
                rdata_q <= '0;
                for (int b = 0; b < `AXI_STRB_W; b++) begin
                    if (dec_stage.wstrb[b]) begin
                        mem[dec_stage.window][dec_stage.word][8*b +: 8] <=
                            dec_stage.wdata[8*b +: 8];
                    end
                end
            end else begin
                resp_q  <= RESP_OKAY;
                // Old word, before any write on this edge
                rdata_q <= mem[dec_stage.window][dec_stage.word];
            end
        end
    end

    always_comb begin
        exec_rsp.valid = exec_valid;
        exec_rsp.resp  = resp_q;
        exec_rsp.rdata = rdata_q;
    end

    assign exec_master     = master_q;
    assign exec_valid_bits = {exec_valid, dec_stage.valid};

endmodule

// ==== source/bus_result.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module bus_result import axi_bus_pkg::*; (
    input  logic                     sys_clk,
    input  logic                     arst_n,
    input  bus_rsp_t                 exec_rsp,
    input  master_idx_t              exec_master,
    output logic                     out_free,
    output bus_rsp_t                 rsp [`MASTER_COUNT],
    input  logic [`MASTER_COUNT-1:0] rsp_ready,
    output logic                     result_full
);

    logic        buf_valid;
    bus_rsp_t    buf_rsp;
    master_idx_t buf_master;
    logic        take;

    // Only the owning master can drain the buffer
    assign take     = buf_valid && rsp_ready[buf_master];
    assign out_free = !buf_valid || take;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;
        end else if (out_free) begin
            buf_valid <= exec_rsp.valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (out_free && exec_rsp.valid) begin
            buf_rsp    <= exec_rsp;
            buf_master <= exec_master;
        end
    end

    always_comb begin
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            rsp[m] = '0;
            if (buf_valid && buf_master == master_idx_t'(m)) begin
                rsp[m]       = buf_rsp;
                rsp[m].valid = 1'b1;
            end
        end
    end

    assign result_full = buf_valid;

endmodule

// ==== source/led_status_pager.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module led_status_pager import status_pkg::*; (
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic [1:0] btn,
    input  logic [2:0] occupancy,
    output logic [7:0] led8,
    output page_idx_t  led4
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] btn_rise;
    page_idx_t  page_q;

    // Two-flop synchroniser plus one flop for edge detect
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign btn_rise = btn_sync & ~btn_prev;

    // Up has priority, both directions wrap
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            page_q <= '0;
        end else if (btn_rise[0]) begin
            page_q <= page_q + page_idx_t'(1);
        end else if (btn_rise[1]) begin
            page_q <= page_q - page_idx_t'(1);
        end
    end

    always_comb begin
        if (page_q == '0) begin
            led8 = {5'b0, occupancy};
        end else if (page_q < page_idx_t'(`PAGE_COUNT / 2)) begin
            led8 = 8'h00;
        end else begin
            led8 = PAGE_PATTERNS[page_q[2:0]];
        end
    end

    assign led4 = page_q;

endmodule

// ==== source/axi_bus_top.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module axi_bus_top import axi_bus_pkg::*, status_pkg::*; (
    input  logic                     sys_clk,
    input  logic                     arst_n,
    input  bus_req_t                 req [`MASTER_COUNT],
    output logic [`MASTER_COUNT-1:0] req_ready,
    output bus_rsp_t                 rsp [`MASTER_COUNT],
    input  logic [`MASTER_COUNT-1:0] rsp_ready,
    input  logic [1:0]               btn,
    output logic [7:0]               led8,
    output page_idx_t                led4
);

    bus_stage_t  dec_stage;
    logic        dec_free;
    bus_rsp_t    exec_rsp;
    master_idx_t exec_master;
    logic        out_free;
    logic [1:0]  exec_valid_bits;
    logic        result_full;

    bus_decode u_bus_decode (
        .sys_clk    (sys_clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_ready  (req_ready),
        .stage_free (dec_free),
        .dec_stage  (dec_stage)
    );

    bus_execute u_bus_execute (
        .sys_clk         (sys_clk),
        .arst_n          (arst_n),
        .dec_stage       (dec_stage),
        .stage_free      (dec_free),
        .out_free        (out_free),
        .exec_rsp        (exec_rsp),
        .exec_master     (exec_master),
        .exec_valid_bits (exec_valid_bits)
    );

    bus_result u_bus_result (
        .sys_clk     (sys_clk),
        .arst_n      (arst_n),
        .exec_rsp    (exec_rsp),
        .exec_master (exec_master),
        .out_free    (out_free),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .result_full (result_full)
    );

    // Occupancy byte, bit 0 decode up to bit 2 result
    led_status_pager u_led_status_pager (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .btn       (btn),
        .occupancy ({result_full, exec_valid_bits}),
        .led8      (led8),
        .led4      (led4)
    );

endmodule

// ==== testbench/tb_axi_bus_top.sv ====
`timescale 1ns/1ps
`include "axi_bus_params.svh"

module tb_axi_bus_top import axi_bus_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int FILL_REQS   = `SLAVE_COUNT * `SLAVE_WORDS;
    localparam int SINGLE_REQS = 200;
    localparam int DUAL_REQS   = 300;
    localparam int STALL_REQS  = 400;
    localparam int PRESSES     = 38;
    // Worst case about 16 cycles per request, 17 per button press
    localparam int MAX_CYCLES  = 16 * (FILL_REQS + SINGLE_REQS + DUAL_REQS + STALL_REQS)
                                 + 17 * PRESSES + 1000;

    localparam logic [7:0] PAGE_BYTES [8] = '{8'h00, 8'h0F, 8'hF0, 8'h0F,
                                              8'hAA, 8'h55, 8'hF0, 8'h0F};

    // Expected response, in acceptance order
    typedef struct packed {
        logic        master;
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [31:0] cyc;
    } exp_t;

    logic                     sys_clk;
    logic                     arst_n;
    bus_req_t                 req [`MASTER_COUNT];
    logic [`MASTER_COUNT-1:0] req_ready;
    bus_rsp_t                 rsp [`MASTER_COUNT];
    logic [`MASTER_COUNT-1:0] rsp_ready;
    logic [1:0]               btn;
    logic [7:0]               led8;
    logic [3:0]               led4;

    exp_t        exp_q [$];
    logic [31:0] model_mem [`SLAVE_COUNT][`SLAVE_WORDS];
    bus_rsp_t    prev_rsp [`MASTER_COUNT];
    logic [1:0]  held;
    logic [1:0]  accepted;
    logic        last_winner;
    logic [3:0]  exp_page;
    string       test_name;
    int          errors;
    int          checks;
    int          cyc;
    int          issued;
    int          target;
    bit          two_masters;
    bit          gaps;
    bit          backpressure;
    bit          fill_mode;

    axi_bus_top UUT (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .req       (req),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .btn       (btn),
        .led8      (led8),
        .led4      (led4)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        int cycle_count;
        cycle_count = 0;
        forever begin
            @(posedge sys_clk);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                $display("Timeout after %0d cycles, the run did not complete", cycle_count);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("error %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    // Page 0 shows which pipeline stages hold a request
    task automatic check_occupancy();
        logic [7:0] occ;
        int         age;
        occ = 8'h00;
        if (!backpressure) begin
            // Without stalls a request sits in stage n for cycle n after acceptance
            foreach (exp_q[i]) begin
                age = cyc - int'(exp_q[i].cyc);
                if (age >= 1 && age <= 3) begin
                    occ[age-1] = 1'b1;
                end
            end
            check_value("occupancy", 32'(occ), 32'(led8));
        end else if ((req[0].valid || req[1].valid) && req_ready == '0) begin
            // A waiting master is refused only with every stage full
            check_value("occupancy", 32'h07, 32'(led8));
        end
    endtask

    // Random single beat, one in eight outside the mapped windows
    function automatic bus_req_t random_req();
        bus_req_t r;
        r.valid = 1'b1;
        r.op    = bus_op_e'($urandom % 2);
        r.addr  = $urandom;
        r.addr[31:30] = 2'b00;
        if ($urandom % 8 == 0) begin
            r.addr[31:30] = 2'($urandom % 3 + 1);
        end
        r.wdata = $urandom;
        r.wstrb = 4'($urandom);
        return r;
    endfunction

    task automatic refill(input int m);
        bus_req_t r;
        r = '0;
        if ((m == 0 || two_masters) && issued < target && !(gaps && $urandom % 3 == 0)) begin
            if (fill_mode) begin
                r.valid = 1'b1;
                r.op    = OP_WRITE;
                r.addr  = {2'b00, 2'(issued / `SLAVE_WORDS), 20'h0,
                           6'(issued % `SLAVE_WORDS), 2'b00};
                r.wdata = $urandom;
                r.wstrb = 4'hF;
            end else begin
                r = random_req();
            end
            issued++;
        end
        req[m] = r;
    endtask

    // Window in bits 29..28, word in bits 7..2
    task automatic model_access(input int m);
        exp_t       e;
        logic [1:0] win;
        logic [5:0] word;
        win      = req[m].addr[29:28];
        word     = req[m].addr[7:2];
        e.master = 1'(m);
        e.resp   = RESP_OKAY;
        e.rdata  = '0;
        e.cyc    = 32'(cyc);
        if (req[m].addr[31:30] != 2'b00) begin
            e.resp = RESP_DECERR;
        end else if (req[m].op == OP_WRITE) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (req[m].wstrb[b]) begin
                    model_mem[win][word][8*b +: 8] = req[m].wdata[8*b +: 8];
                end
            end
        end else begin
            e.rdata = model_mem[win][word];
        end
        exp_q.push_back(e);
    endtask

    // Sees the handshakes of the coming rising edge
    task automatic observe();
        bus_rsp_t r;
        exp_t     e;
        check_occupancy();
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            accepted[m] = req_ready[m] && req[m].valid;
            if (req_ready[m] && !req[m].valid) begin
                check_cond(1'b0, "ready given to a master without a request");
            end
            if (accepted[m]) begin
                // Loser of the last arbitration wins a tie
                if (req[0].valid && req[1].valid) begin
                    check_value("winner", 32'(!last_winner), 32'(m));
                end
                last_winner = 1'(m);
                model_access(m);
            end
        end
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            r = rsp[m];
            if (held[m]) begin
                check_cond(r == prev_rsp[m], "response changed while it was not taken");
            end
            held[m]     = r.valid && !rsp_ready[m];
            prev_rsp[m] = r;
            if (r.valid && rsp_ready[m]) begin
                if (exp_q.size() == 0) begin
                    check_cond(1'b0, "response with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value("master", 32'(e.master), 32'(m));
                    check_value("resp", 32'(e.resp), 32'(r.resp));
                    check_value("rdata", e.rdata, r.rdata);
                    if (!backpressure) begin
                        check_value("latency", 32'd3, 32'(cyc) - e.cyc);
                    end
                end
            end
        end
        cyc++;
    endtask

    task automatic bus_cycle();
        @(negedge sys_clk);
        for (int m = 0; m < `MASTER_COUNT; m++) begin
            if (!req[m].valid || accepted[m]) begin
                refill(m);
            end
        end
        rsp_ready = backpressure ? 2'($urandom) : 2'b11;
        #1;
        observe();
    endtask

    task automatic run_phase(input string name, input int count, input bit both,
                             input bit gap, input bit stall);
        test_name    = name;
        target       = count;
        issued       = 0;
        two_masters  = both;
        gaps         = gap;
        backpressure = stall;
        while (issued < target || req[0].valid || req[1].valid || exp_q.size() != 0) begin
            bus_cycle();
        end
    endtask

    function automatic logic [7:0] page_byte(input logic [3:0] page);
        if (page < 4'd8) begin
            return 8'h00;
        end
        return PAGE_BYTES[page[2:0]];
    endfunction

    // Bit 0 steps up, bit 1 steps down
    task automatic press_button(input int b);
        @(negedge sys_clk);
        btn[b]   = 1'b1;
        exp_page = (b == 0) ? exp_page + 4'd1 : exp_page - 4'd1;
        repeat (8) @(negedge sys_clk);
        check_value("led4", 32'(exp_page), 32'(led4));
        check_value("led8", 32'(page_byte(exp_page)), 32'(led8));
        btn[b] = 1'b0;
        repeat (8) @(negedge sys_clk);
    endtask

    initial begin
        void'($urandom(72));
        arst_n      = 1'b0;
        rsp_ready   = 2'b11;
        btn         = 2'b00;
        req[0]      = '0;
        req[1]      = '0;
        held        = '0;
        accepted    = '0;
        last_winner = 1'b1;
        exp_page    = '0;
        errors      = 0;
        checks      = 0;
        cyc         = 0;
        test_name   = "reset";
        fill_mode   = 1'b0;
        repeat (10) @(negedge sys_clk);
        arst_n = 1'b1;
        @(negedge sys_clk);
        check_value("led4", 32'd0, 32'(led4));
        // Stage valid bits on page 0
        check_value("led8", 32'd0, 32'(led8));
        check_cond(req_ready == '0 && !rsp[0].valid && !rsp[1].valid,
                   "handshake outputs not low after reset");

        // Known contents first, then random traffic
        fill_mode = 1'b1;
        run_phase("fill", FILL_REQS, 1'b0, 1'b0, 1'b0);
        fill_mode = 1'b0;
        run_phase("readback", SINGLE_REQS, 1'b0, 1'b0, 1'b0);
        run_phase("two_masters", DUAL_REQS, 1'b1, 1'b0, 1'b0);
        run_phase("backpressure", STALL_REQS, 1'b1, 1'b1, 1'b1);

        test_name = "pager";
        repeat (16) press_button(0);
        repeat (2) press_button(1);
        repeat (PRESSES - 18) press_button($urandom % 2);

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== axi_bus_top.f ====
+incdir+source
source/axi_bus_pkg.sv
source/status_pkg.sv
source/bus_decode.sv
source/bus_execute.sv
source/bus_result.sv
source/led_status_pager.sv
source/axi_bus_top.sv
testbench/tb_axi_bus_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_axi_bus_top
RTL_TOP   ?= axi_bus_top
FILELIST  ?= axi_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
